// File: common/ls_pkg.sv
`default_nettype none

package ls_pkg;

	// data and address width
	localparam int xlen = 32;

	// store queue geometry
	localparam int sq_depth = 4;
	localparam int sq_idx_len = 2;

	// data memory geometry with the word index taken from addr[7:2]
	localparam int mem_words = 64;
	localparam int mem_idx_len = 6;

	// memory operation carried with each issue
	typedef enum logic [1:0] {
		ls_none  = 2'd0,
		ls_load  = 2'd1,
		ls_store = 2'd2
	} ls_op_t;

endpackage

`default_nettype wire

// File: common/agu_lsq_if.sv
`default_nettype none

interface agu_lsq_if;
	logic                    op_valid;
	ls_pkg::ls_op_t          op;
	logic [ls_pkg::xlen-1:0] addr;
	logic [ls_pkg::xlen-1:0] value;
	// room left in the queue with the held store counted
	logic                    sq_space;
	// flush pulse shared by both ends
	logic                    squash;

	modport producer (
		output op_valid,
		output op,
		output addr,
		output value,
		input  sq_space,
		input  squash
	);

	modport buffer (
		input  op_valid,
		input  op,
		input  addr,
		input  value,
		output sq_space,
		input  squash
	);
endinterface

`default_nettype wire

// File: common/mem_if.sv
`default_nettype none

interface mem_if;
	logic                           rd_en;
	logic [ls_pkg::mem_idx_len-1:0] rd_idx;
	logic [ls_pkg::xlen-1:0]        rd_data;
	logic                           wr_en;
	logic [ls_pkg::mem_idx_len-1:0] wr_idx;
	logic [ls_pkg::xlen-1:0]        wr_data;

	modport buffer (
		output rd_en,
		output rd_idx,
		input  rd_data,
		output wr_en,
		output wr_idx,
		output wr_data
	);

	modport memory (
		input  rd_en,
		input  rd_idx,
		output rd_data,
		input  wr_en,
		input  wr_idx,
		input  wr_data
	);
endinterface

`default_nettype wire

// File: design/fu_ls.sv
`default_nettype none

module fu_ls (
	input  wire logic                    clock,
	input  wire logic                    rst_n,
	input  wire logic                    issue_valid,
	input  wire ls_pkg::ls_op_t          issue_op,
	input  wire logic [ls_pkg::xlen-1:0] issue_inst,
	input  wire logic [ls_pkg::xlen-1:0] issue_base,
	input  wire logic [ls_pkg::xlen-1:0] issue_value,
	output logic                         issue_ready,
	agu_lsq_if.producer                  agu
);

	logic                    held_valid;
	ls_pkg::ls_op_t          held_op;
	logic [ls_pkg::xlen-1:0] held_inst;
	logic [ls_pkg::xlen-1:0] held_base;
	logic [ls_pkg::xlen-1:0] held_value;
	logic [ls_pkg::xlen-1:0] i_imm;
	logic [ls_pkg::xlen-1:0] s_imm;
	logic                    take;

	// the queue already counts a store sitting here
	assign issue_ready = agu.sq_space;
	assign take = issue_valid && issue_ready && (issue_op != ls_pkg::ls_none);

	// held for one cycle only; a store leaves after one cycle and its
	// slot then shows up in the queue count instead
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			held_valid <= 1'b0;
			held_op <= ls_pkg::ls_none;
		end else if (agu.squash) begin
			held_valid <= 1'b0;
			held_op <= ls_pkg::ls_none;
		end else begin
			held_valid <= take;
			if (take)
				held_op <= issue_op;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			held_inst <= issue_inst;
			held_base <= issue_base;
			held_value <= issue_value;
		end
	end

	// loads use the I-type immediate, stores the S-type split field
	assign i_imm = {{20{held_inst[31]}}, held_inst[31:20]};
	assign s_imm = {{20{held_inst[31]}}, held_inst[31:25], held_inst[11:7]};

	assign agu.op_valid = held_valid;
	assign agu.op = held_op;
	assign agu.addr = held_base + ((held_op == ls_pkg::ls_store) ? s_imm : i_imm);
	assign agu.value = held_value;

endmodule

`default_nettype wire

// File: store_queue/store_queue.sv
`default_nettype none

module store_queue (
	input  wire logic                      clock,
	input  wire logic                      rst_n,
	input  wire logic                      commit,
	agu_lsq_if.buffer                      agu,
	mem_if.buffer                          mem,
	output logic                           load_valid,
	output logic [ls_pkg::xlen-1:0]        load_data,
	output logic                           load_forwarded,
	output logic [ls_pkg::sq_idx_len:0]    sq_count
);

	logic [ls_pkg::mem_idx_len-1:0] sq_idx [ls_pkg::sq_depth];
	logic [ls_pkg::xlen-1:0]        sq_data [ls_pkg::sq_depth];
	logic [ls_pkg::sq_idx_len-1:0]  head;
	logic [ls_pkg::sq_idx_len-1:0]  tail;
	logic [ls_pkg::sq_idx_len:0]    count;
	logic [ls_pkg::sq_idx_len:0]    pending;

	logic                           st_in;
	logic                           push;
	logic                           pop;
	logic                           ld;
	logic [ls_pkg::mem_idx_len-1:0] op_idx;

	logic                           fwd_hit;
	logic [ls_pkg::xlen-1:0]        fwd_data;
	logic                           ld_pend_q;
	logic                           fwd_hit_q;
	logic [ls_pkg::xlen-1:0]        fwd_data_q;

	assign st_in = agu.op_valid && (agu.op == ls_pkg::ls_store);
	assign push = st_in && !agu.squash;
	assign pop = commit && (count != '0) && !agu.squash;
	assign ld = agu.op_valid && (agu.op == ls_pkg::ls_load) && !agu.squash;
	assign op_idx = agu.addr[ls_pkg::mem_idx_len+1:2];

	// space check includes the store currently held in fu_ls
	assign pending = count + {{ls_pkg::sq_idx_len{1'b0}}, st_in};
	assign agu.sq_space = pending < ls_pkg::sq_depth[ls_pkg::sq_idx_len:0];
	assign sq_count = count;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (agu.squash) begin
			// nothing in here is committed yet
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			sq_idx[tail] <= op_idx;
			sq_data[tail] <= agu.value;
		end
	end

	// oldest drains into memory on commit
	assign mem.wr_en = pop;
	assign mem.wr_idx = sq_idx[head];
	assign mem.wr_data = sq_data[head];

	// walk oldest to youngest so a younger match replaces an older one
	always_comb begin
		logic [ls_pkg::sq_idx_len-1:0] slot;
		fwd_hit = 1'b0;
		fwd_data = '0;
		for (int i = 0; i < ls_pkg::sq_depth; i++) begin
			slot = head + i[ls_pkg::sq_idx_len-1:0];
			if ((i < count) && (sq_idx[slot] == op_idx)) begin
				fwd_hit = 1'b1;
				fwd_data = sq_data[slot];
			end
		end
	end

	// memory is only read on a miss
	assign mem.rd_en = ld && !fwd_hit;
	assign mem.rd_idx = op_idx;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ld_pend_q <= 1'b0;
			fwd_hit_q <= 1'b0;
		end else begin
			ld_pend_q <= ld;
			fwd_hit_q <= ld && fwd_hit;
		end
	end

	always_ff @(posedge clock) begin
		if (ld)
			fwd_data_q <= fwd_data;
	end

	assign load_valid = ld_pend_q;
	assign load_forwarded = fwd_hit_q;
	assign load_data = fwd_hit_q ? fwd_data_q : mem.rd_data;

endmodule

`default_nettype wire

// File: design/data_mem.sv
`default_nettype none

module data_mem (
	input  wire logic clock,
	input  wire logic rst_n,
	mem_if.memory     mem
);

	logic [ls_pkg::xlen-1:0] words [ls_pkg::mem_words];
	logic [ls_pkg::xlen-1:0] rd_q;

	// same-word read and write at one edge returns the old value,
	// the queue forwards the new one in that case
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ls_pkg::mem_words; i++)
				words[i] <= '0;
			rd_q <= '0;
		end else begin
			if (mem.wr_en)
				words[mem.wr_idx] <= mem.wr_data;
			if (mem.rd_en)
				rd_q <= words[mem.rd_idx];
		end
	end

	assign mem.rd_data = rd_q;

endmodule

`default_nettype wire

// File: design/ls_unit.sv
`default_nettype none

module ls_unit (
	input  wire logic                    clock,
	input  wire logic                    rst_n,
	input  wire logic                    issue_valid,
	input  wire ls_pkg::ls_op_t          issue_op,
	input  wire logic [ls_pkg::xlen-1:0] issue_inst,
	input  wire logic [ls_pkg::xlen-1:0] issue_base,
	input  wire logic [ls_pkg::xlen-1:0] issue_value,
	input  wire logic                    commit,
	input  wire logic                    squash,
	output logic                         issue_ready,
	output logic                         load_valid,
	output logic [ls_pkg::xlen-1:0]      load_data,
	output logic                         load_forwarded,
	output logic [ls_pkg::sq_idx_len:0]  sq_count
);

	agu_lsq_if agu ();
	mem_if     mem ();

	// flush reaches both fu_ls and the queue
	assign agu.squash = squash;

	fu_ls u_fu_ls (
		.clock       (clock),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_inst  (issue_inst),
		.issue_base  (issue_base),
		.issue_value (issue_value),
		.issue_ready (issue_ready),
		.agu         (agu.producer)
	);

	store_queue u_store_queue (
		.clock          (clock),
		.rst_n          (rst_n),
		.commit         (commit),
		.agu            (agu.buffer),
		.mem            (mem.buffer),
		.load_valid     (load_valid),
		.load_data      (load_data),
		.load_forwarded (load_forwarded),
		.sq_count       (sq_count)
	);

	data_mem u_data_mem (
		.clock (clock),
		.rst_n (rst_n),
		.mem   (mem.memory)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic rst_n
);

	// period of 10
	initial clock = 1'b0;
	always #5 clock = ~clock;

	// low for the first 8 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clock);
		#2;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_ls_unit.sv
`default_nettype none

module tb_ls_unit;

	logic                           clock;
	logic                           rst_n;
	logic                           issue_valid;
	ls_pkg::ls_op_t                 issue_op;
	logic [ls_pkg::xlen-1:0]        issue_inst, issue_base, issue_value;
	logic                           commit;
	logic                           squash;
	logic                           issue_ready;
	logic                           load_valid;
	logic [ls_pkg::xlen-1:0]        load_data;
	logic                           load_forwarded;
	logic [ls_pkg::sq_idx_len:0]    sq_count;

	// stimulus lines as read from the file
	ls_pkg::ls_op_t                 s_op[$];
	logic [31:0]                    s_inst[$], s_base[$], s_value[$], s_exp_data[$];
	logic                           s_commit[$], s_squash[$], s_exp_fwd[$];

	// reference model of the queued stores, memory and the operation held in the AGU
	logic [ls_pkg::mem_idx_len-1:0] q_idx[$];
	logic [31:0]                    q_data[$];
	logic [31:0]                    ref_mem [ls_pkg::mem_words];
	ls_pkg::ls_op_t                 h_op;
	logic [ls_pkg::mem_idx_len-1:0] h_idx;
	logic [31:0]                    h_data, h_exp_data;
	logic                           h_exp_fwd;

	// load results still to come and the cycle each is due in
	int                             e_due[$];
	logic [31:0]                    e_data[$];
	logic                           e_fwd[$];

	int cyc, li, val_errors, other_errors;
	bit first, stall, loaded;

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.rst_n (rst_n)
	);

	ls_unit DUT (
		.clock          (clock),
		.rst_n          (rst_n),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.issue_inst     (issue_inst),
		.issue_base     (issue_base),
		.issue_value    (issue_value),
		.commit         (commit),
		.squash         (squash),
		.issue_ready    (issue_ready),
		.load_valid     (load_valid),
		.load_data      (load_data),
		.load_forwarded (load_forwarded),
		.sq_count       (sq_count)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			val_errors++;
		end
	endtask

	// word index from base plus I-type (load) or S-type (store) immediate
	function automatic logic [ls_pkg::mem_idx_len-1:0] word_of(input ls_pkg::ls_op_t op,
			input logic [31:0] inst, input logic [31:0] base);
		logic [11:0] imm;
		logic [31:0] addr;
		if (op == ls_pkg::ls_store)
			imm = {inst[31:25], inst[11:7]};
		else
			imm = inst[31:20];
		addr = base + {{20{imm[11]}}, imm};
		return addr[7:2];
	endfunction

	task automatic read_stim();
		int fd, n, op, cm, sq, fwd;
		string line;
		logic [31:0] inst, base, value, data;
		fd = $fopen("testbench/ls_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file testbench/ls_stim.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h", op, inst, base, value, cm, sq, data, fwd);
			if (n != 8) begin
				$display("malformed stimulus line: %s", line);
				other_errors++;
				continue;
			end
			s_op.push_back(ls_pkg::ls_op_t'(op[1:0]));
			s_inst.push_back(inst);
			s_base.push_back(base);
			s_value.push_back(value);
			s_commit.push_back(cm[0]);
			s_squash.push_back(sq[0]);
			s_exp_data.push_back(data);
			s_exp_fwd.push_back(fwd[0]);
		end
		$fclose(fd);
	endtask

	task automatic drive_line(input int k, input bit fresh);
		issue_valid = (s_op[k] != ls_pkg::ls_none);
		issue_op = s_op[k];
		issue_inst = s_inst[k];
		issue_base = s_base[k];
		issue_value = s_value[k];
		// a held line repeats its issue but not its commit or squash
		commit = fresh && s_commit[k];
		squash = fresh && s_squash[k];
	endtask

	task automatic drive_idle();
		issue_valid = 1'b0;
		issue_op = ls_pkg::ls_none;
		commit = 1'b0;
		squash = 1'b0;
	endtask

	// checks at the falling edge and steps the model over the next rising edge
	task automatic end_cycle(output bit stalled);
		int pend;
		bit take;
		logic [31:0] ld_val;
		logic ld_fwd;
		if (e_due.size() > 0 && e_due[0] == cyc) begin
			if (load_valid !== 1'b1) begin
				$display("t=%0t load_valid did not pulse for an issued load", $time);
				other_errors++;
			end else begin
				check_val("load_data", load_data, e_data[0]);
				check_val("load_forwarded", load_forwarded, e_fwd[0]);
			end
			void'(e_due.pop_front());
			void'(e_data.pop_front());
			void'(e_fwd.pop_front());
		end else if (load_valid !== 1'b0) begin
			$display("t=%0t load_valid pulsed with no load result due", $time);
			other_errors++;
		end
		pend = q_idx.size() + ((h_op == ls_pkg::ls_store) ? 1 : 0);
		check_val("sq_count", sq_count, q_idx.size());
		check_val("issue_ready", issue_ready, pend < ls_pkg::sq_depth);
		take = issue_valid && issue_ready && !squash;
		stalled = issue_valid && !issue_ready;
		if (squash) begin
			q_idx.delete();
			q_data.delete();
			h_op = ls_pkg::ls_none;
		end else begin
			if (h_op == ls_pkg::ls_load) begin
				ld_fwd = 1'b0;
				ld_val = ref_mem[h_idx];
				// later entries are younger
				foreach (q_idx[i]) begin
					if (q_idx[i] == h_idx) begin
						ld_fwd = 1'b1;
						ld_val = q_data[i];
					end
				end
				check_val("stim expected load_data", h_exp_data, ld_val);
				check_val("stim expected load_forwarded", h_exp_fwd, ld_fwd);
				e_due.push_back(cyc + 1);
				e_data.push_back(h_exp_data);
				e_fwd.push_back(h_exp_fwd);
			end
			if (commit && q_idx.size() > 0) begin
				ref_mem[q_idx[0]] = q_data[0];
				void'(q_idx.pop_front());
				void'(q_data.pop_front());
			end
			if (h_op == ls_pkg::ls_store) begin
				q_idx.push_back(h_idx);
				q_data.push_back(h_data);
			end
			h_op = ls_pkg::ls_none;
			if (take) begin
				h_op = issue_op;
				h_idx = word_of(issue_op, issue_inst, issue_base);
				h_data = issue_value;
				h_exp_data = s_exp_data[li];
				h_exp_fwd = s_exp_fwd[li];
			end
		end
	endtask

	initial begin
		drive_idle();
		issue_inst = '0;
		issue_base = '0;
		issue_value = '0;
		val_errors = 0;
		other_errors = 0;
		cyc = 0;
		h_op = ls_pkg::ls_none;
		foreach (ref_mem[i])
			ref_mem[i] = '0;
		read_stim();
		if (s_op.size() == 0) begin
			$display("no stimulus lines were read");
			other_errors++;
		end
		loaded = 1'b1;
		wait (rst_n === 1'b1);
		li = 0;
		first = 1'b1;
		while (li < s_op.size()) begin
			@(posedge clock);
			#1;
			cyc++;
			drive_line(li, first);
			@(negedge clock);
			end_cycle(stall);
			first = !stall;
			if (!stall)
				li++;
		end
		// let the last loads come back
		repeat (4) begin
			@(posedge clock);
			#1;
			cyc++;
			drive_idle();
			@(negedge clock);
			end_cycle(stall);
		end
		if (e_due.size() != 0) begin
			$display("%0d load results never arrived", e_due.size());
			other_errors++;
		end
		$display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
		if (val_errors + other_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// bound on run length from the number of stimulus lines
	initial begin
		wait (loaded);
		#(s_op.size() * 10 + 200);
		$display("watchdog expired before the stimulus finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
common/ls_pkg.sv
common/agu_lsq_if.sv
common/mem_if.sv
design/fu_ls.sv
store_queue/store_queue.sv
design/data_mem.sv
design/ls_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_ls_unit.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the load/store testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_ls_unit \
	-Mdir obj_dir -o sim_ls_unit
./obj_dir/sim_ls_unit > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0

// File: testbench/ls_stim.txt
# columns: op inst base value commit squash exp_load_data exp_load_forwarded
# all hex; op 0 none, 1 load, 2 store; the exp columns only count on load lines
# unwritten word right after reset
1 00012183 00000020 00000000 0 0 00000000 0
0 00000000 00000000 00000000 0 0 00000000 0
# store with S-imm -4 and load with I-imm +8 meet at 0x40
2 fe112e23 00000044 aaaa0001 0 0 00000000 0
1 00822183 00000038 00000000 0 0 aaaa0001 1
# two stores to one word, the younger forwards
2 00112023 00000080 11110000 0 0 00000000 0
2 00112023 00000080 22220000 0 0 00000000 0
1 00012183 00000080 00000000 0 0 22220000 1
# drain the queue, then commit once more while empty
0 00000000 00000000 00000000 1 0 00000000 0
0 00000000 00000000 00000000 1 0 00000000 0
0 00000000 00000000 00000000 1 0 00000000 0
0 00000000 00000000 00000000 1 0 00000000 0
1 00012183 00000080 00000000 0 0 22220000 0
1 00012183 00000040 00000000 0 0 aaaa0001 0
# fill the queue; the fifth store stalls until its commit frees a slot
2 00112023 000000c0 00000030 0 0 00000000 0
2 00112023 000000c4 00000031 0 0 00000000 0
2 00112023 000000c8 00000032 0 0 00000000 0
2 00112023 000000cc 00000033 0 0 00000000 0
2 00112023 000000c0 00000034 1 0 00000000 0
0 00000000 00000000 00000000 1 0 00000000 0
1 00012183 000000c0 00000000 0 0 00000034 1
# squash with stores queued and a load in flight
1 00012183 000000c8 00000000 0 0 00000000 0
0 00000000 00000000 00000000 0 1 00000000 0
1 00012183 000000c0 00000000 0 0 00000030 0
1 00012183 000000c8 00000000 0 0 00000000 0
# queue refills after the squash
2 00112023 000000c8 00000055 0 0 00000000 0
1 00012183 000000c8 00000000 0 0 00000055 1
0 00000000 00000000 00000000 1 0 00000000 0
1 00012183 000000c8 00000000 0 0 00000055 0
